// File: common/buf_cfg_pkg.sv
// frame buffer geometry
`default_nettype none

package buf_cfg_pkg;

  // --------------------
  // bank layout
  // --------------------
  localparam int BNUM_W     = 2;              // bank index width
  localparam int BNUM       = 2 ** BNUM_W;    // 4 banks in the ring
  localparam int BANK_AW    = 3;              // word address inside one bank
  localparam int BANK_WORDS = 8;              // words per frame, fills one bank

  // data path and whole ram
  localparam int DATA_W     = 16;
  localparam int RAM_AW     = BNUM_W + BANK_AW; // {bank, word}

  // toggle synchronizer depth in the destination domain
  localparam int SYNC_LEN   = 3;

  // --------------------
  // types
  // --------------------
  typedef logic [BNUM_W-1:0] bank_idx_t;      // bank number
  typedef logic [BNUM-1:0]   bank_vec_t;      // one flag per bank

endpackage

`default_nettype wire

// File: common/buf_type_pkg.sv
// stream payload types
`default_nettype none

package buf_type_pkg;

  // --------------------
  // write side payload
  // --------------------
  typedef struct packed {
    logic [buf_cfg_pkg::DATA_W-1:0] data;   // raw sample word
  } sample_t;

  // --------------------
  // read side payload
  // --------------------
  // one beat of the output stream, last closes a frame
  typedef struct packed {
    logic [buf_cfg_pkg::DATA_W-1:0] data;
    logic                           last;   // high on word 7 of a bank
  } beat_t;

endpackage

`default_nettype wire

// File: logic/pulse_sync.sv
// toggle pulse synchronizer
`timescale 1ns/10ps
`default_nettype none

module pulse_sync
  import buf_cfg_pkg::*;
(
  input  logic clk_in,
  input  logic reset_in,
  input  logic clk_out,
  input  logic reset_out,
  input  logic pulse_in,    // single cycle pulse, clk_in domain
  output logic pulse_out    // single cycle pulse, clk_out domain
);

  logic              src_toggle;   // flips once per input pulse
  logic [SYNC_LEN:0] sync_chain;   // SYNC_LEN sync stages plus one history stage
  logic [SYNC_LEN-1:0] chain_edges; // flips travelling through the chain

  // --------------------
  // source domain
  // --------------------
  always_ff @(posedge clk_in or posedge reset_in) begin
    if (reset_in) begin
      src_toggle <= 1'b0;
    end else if (pulse_in) begin
      src_toggle <= ~src_toggle;
    end
  end

  // --------------------
  // destination domain
  // --------------------
  always_ff @(posedge clk_out or posedge reset_out) begin
    if (reset_out) begin
      sync_chain <= '0;
      pulse_out  <= 1'b0;
    end else begin
      sync_chain <= {sync_chain[SYNC_LEN-1:0], src_toggle};      // bit 0 is the metastable stage
      pulse_out  <= sync_chain[SYNC_LEN] ^ sync_chain[SYNC_LEN-1]; // any level change is one pulse
    end
  end

  assign chain_edges = sync_chain[SYNC_LEN:1] ^ sync_chain[SYNC_LEN-1:0];

  // a second flip must not enter while the first one is still on its way,
  // otherwise two pulses may merge into one
  a_pulse_spacing : assert property (
    @(posedge clk_out) disable iff (reset_out) $onehot0(chain_edges)
  ) else $error("pulse_sync: input pulses closer than the crossing time");

endmodule

`default_nettype wire

// File: bank/bank_ctrl.sv
// dual clock bank ownership
`timescale 1ns/10ps
`default_nettype none

module bank_ctrl
  import buf_cfg_pkg::*;
(
  input  logic      iwclk,
  input  logic      iwreset,
  // write side
  input  logic      wfull,        // writer finished the frame in wbank
  output bank_idx_t wbank,        // bank being filled
  output logic      wbank_busy,   // wbank still owned by the read side
  // read side
  input  logic      irclk,
  input  logic      irreset,
  input  logic      rempty,       // reader drained rbank
  output bank_idx_t rbank,        // bank being drained
  output logic      rbank_full,   // rbank holds a complete frame
  // status
  output logic      w_any_free,
  output logic      w_all_full,
  output logic      r_any_full,
  output logic      r_all_empty
);

  bank_vec_t w_busy;        // banks not writable, seen from iwclk
  bank_vec_t r_busy;        // banks with a frame, seen from irclk
  bank_vec_t wfull_vec;     // full pulse steered to its bank
  bank_vec_t rempty_vec;    // empty pulse steered to its bank
  bank_vec_t full_at_r;     // full pulses after the crossing
  bank_vec_t empty_at_w;    // empty pulses after the crossing
  bank_idx_t wptr;
  bank_idx_t rptr;
  bank_idx_t wptr_next;
  logic      w_release;     // some bank came back from the read side
  logic      w_advance;

  assign wfull_vec  = bank_vec_t'(wfull) << wptr;
  assign rempty_vec = bank_vec_t'(rempty) << rptr;

  // --------------------
  // write side
  // --------------------
  assign wptr_next = wptr + 1'b1;   // ring order, wraps at BNUM
  assign w_release = |empty_at_w;

  // move on when the next bank is free, or when the stalled pointer gets one back
  assign w_advance = (wfull & w_release) | (wfull & ~w_busy[wptr_next])
                   | (w_release & w_busy[wptr]);

  always_ff @(posedge iwclk or posedge iwreset) begin
    if (iwreset) begin
      w_busy <= '0;
      wptr   <= '0;
    end else begin
      for (int i = 0; i < BNUM; i++) begin
        if (wfull_vec[i]) begin
          w_busy[i] <= 1'b1;          // handed to the reader
        end else if (empty_at_w[i]) begin
          w_busy[i] <= 1'b0;          // reader gave it back
        end
      end
      if (w_advance) begin
        wptr <= wptr_next;
      end
    end
  end

  assign wbank      = wptr;
  assign wbank_busy = w_busy[wptr];
  assign w_any_free = |(~w_busy);
  assign w_all_full = &w_busy;

  // --------------------
  // read side
  // --------------------
  always_ff @(posedge irclk or posedge irreset) begin
    if (irreset) begin
      r_busy <= '0;
      rptr   <= '0;
    end else begin
      for (int i = 0; i < BNUM; i++) begin
        if (full_at_r[i]) begin
          r_busy[i] <= 1'b1;
        end else if (rempty_vec[i]) begin
          r_busy[i] <= 1'b0;
        end
      end
      if (rempty) begin
        rptr <= rptr + 1'b1;          // frames are drained in fill order
      end
    end
  end

  assign rbank       = rptr;
  assign rbank_full  = r_busy[rptr];
  assign r_any_full  = |r_busy;
  assign r_all_empty = &(~r_busy);

  // --------------------
  // crossings, one pair per bank
  // --------------------
  for (genvar g = 0; g < BNUM; g++) begin : g_sync
    pulse_sync i_full_sync (
      .clk_in    (iwclk),
      .reset_in  (iwreset),
      .clk_out   (irclk),
      .reset_out (irreset),
      .pulse_in  (wfull_vec[g]),
      .pulse_out (full_at_r[g])
    );

    pulse_sync i_empty_sync (
      .clk_in    (irclk),
      .reset_in  (irreset),
      .clk_out   (iwclk),
      .reset_out (iwreset),
      .pulse_in  (rempty_vec[g]),
      .pulse_out (empty_at_w[g])
    );
  end

  // writer must never complete a frame into a bank the reader still owns
  a_wfull_free : assert property (
    @(posedge iwclk) disable iff (iwreset) wfull |-> !wbank_busy
  ) else $error("bank_ctrl: wfull on a busy bank");

  // reader may only release a bank that holds a frame
  a_rempty_full : assert property (
    @(posedge irclk) disable iff (irreset) rempty |-> rbank_full
  ) else $error("bank_ctrl: rempty on an empty bank");

endmodule

`default_nettype wire

// File: bank/bank_ram.sv
// dual clock bank memory
`timescale 1ns/10ps
`default_nettype none

module bank_ram
  import buf_cfg_pkg::*;
  import buf_type_pkg::*;
(
  // write port
  input  logic              iwclk,
  input  logic              we,
  input  logic [RAM_AW-1:0] waddr,   // {bank, word}
  input  sample_t           wdata,
  // read port
  input  logic              irclk,
  input  logic [RAM_AW-1:0] raddr,   // {bank, word}
  output sample_t           rdata    // valid one irclk after raddr
);

  // all banks back to back, bank number in the upper address bits
  sample_t mem [BNUM*BANK_WORDS];

  // --------------------
  // write port
  // --------------------
  always_ff @(posedge iwclk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // --------------------
  // read port
  // --------------------
  always_ff @(posedge irclk) begin
    rdata <= mem[raddr];   // reads every cycle, hold raddr to hold rdata
  end

endmodule

`default_nettype wire

// File: logic/bank_writer.sv
// bank fill logic
`timescale 1ns/10ps
`default_nettype none

module bank_writer
  import buf_cfg_pkg::*;
  import buf_type_pkg::*;
(
  input  logic              iwclk,
  input  logic              iwreset,
  // input stream
  input  logic              in_valid,
  output logic              in_ready,
  input  sample_t           in_sample,
  // bank control
  input  bank_idx_t         wbank,
  input  logic              wbank_busy,
  output logic              wfull,      // word 7 written this cycle
  // ram write port
  output logic              we,
  output logic [RAM_AW-1:0] waddr,
  output sample_t           wdata
);

  logic [BANK_AW-1:0] wcnt;     // word offset inside wbank
  logic               accept;   // input handshake
  logic               wlast;    // current word closes the frame

  // --------------------
  // handshake
  // --------------------
  assign in_ready = ~wbank_busy;             // free bank means no stall
  assign accept   = in_valid & ~wbank_busy;
  assign wlast    = (wcnt == BANK_AW'(BANK_WORDS - 1));

  // --------------------
  // word counter
  // --------------------
  always_ff @(posedge iwclk or posedge iwreset) begin
    if (iwreset) begin
      wcnt <= '0;
    end else if (accept) begin
      wcnt <= wlast ? '0 : wcnt + 1'b1;      // wrap for the next bank
    end
  end

  // ram port, straight from the handshake
  assign we    = accept;
  assign waddr = {wbank, wcnt};
  assign wdata = in_sample;

  assign wfull = accept & wlast;             // one pulse per complete frame

endmodule

`default_nettype wire

// File: logic/bank_reader.sv
// bank drain logic
`timescale 1ns/10ps
`default_nettype none

module bank_reader
  import buf_cfg_pkg::*;
  import buf_type_pkg::*;
(
  input  logic              irclk,
  input  logic              irreset,
  // bank control
  input  bank_idx_t         rbank,
  input  logic              rbank_full,
  output logic              rempty,     // last beat of the bank transferred
  // ram read port
  output logic [RAM_AW-1:0] raddr,
  input  sample_t           rdata,
  // output stream
  output logic              out_valid,
  input  logic              out_ready,
  output beat_t             out_beat
);

  logic [BANK_AW-1:0] rcnt;        // word offset of the next read
  logic [RAM_AW-1:0]  hold_addr;   // address behind the beat on the output
  logic               done;        // all words of rbank issued
  logic               last_q;      // beat on the output closes the frame
  logic               load;        // issue one address this cycle

  // --------------------
  // address stage
  // --------------------
  // a new read only when the output register is empty or moving
  assign load  = rbank_full & ~done & (~out_valid | out_ready);
  assign raddr = load ? {rbank, rcnt} : hold_addr; // stall keeps rdata in place

  always_ff @(posedge irclk or posedge irreset) begin
    if (irreset) begin
      rcnt      <= '0;
      hold_addr <= '0;
      done      <= 1'b0;
      out_valid <= 1'b0;
      last_q    <= 1'b0;
    end else begin
      if (load) begin
        rcnt      <= rcnt + 1'b1;                      // wraps after word 7
        hold_addr <= {rbank, rcnt};
        out_valid <= 1'b1;                             // rdata lands next cycle
        last_q    <= (rcnt == BANK_AW'(BANK_WORDS - 1));
        if (rcnt == BANK_AW'(BANK_WORDS - 1)) begin
          done <= 1'b1;                                // wait for the handover
        end
      end else if (out_ready) begin
        out_valid <= 1'b0;                             // beat taken, nothing new
      end
      if (rempty) begin
        done <= 1'b0;                                  // next bank from next cycle
      end
    end
  end

  // --------------------
  // output stage
  // --------------------
  // the ram read register is the data half of the output register
  assign out_beat = '{data: rdata.data, last: last_q};
  assign rempty   = out_valid & out_ready & last_q;

  // stalled beat holds, across the ram read register
  a_stall_stable : assert property (
    @(posedge irclk) disable iff (irreset)
    (out_valid && !out_ready) |=> (out_valid && $stable(out_beat))
  ) else $error("bank_reader: out_beat changed while stalled");

endmodule

`default_nettype wire

// File: logic/frame_buffer_top.sv
// dual clock frame buffer
`timescale 1ns/10ps
`default_nettype none

module frame_buffer_top
  import buf_cfg_pkg::*;
  import buf_type_pkg::*;
(
  // write clock domain
  input  logic    iwclk,
  input  logic    iwreset,
  input  logic    in_valid,
  output logic    in_ready,
  input  sample_t in_sample,
  // read clock domain
  input  logic    irclk,
  input  logic    irreset,
  output logic    out_valid,
  input  logic    out_ready,
  output beat_t   out_beat,
  // bank status
  output logic    w_any_free,
  output logic    w_all_full,
  output logic    r_any_full,
  output logic    r_all_empty
);

  // --------------------
  // internal wiring
  // --------------------
  bank_idx_t         wbank;
  bank_idx_t         rbank;
  logic              wbank_busy;
  logic              rbank_full;
  logic              wfull;
  logic              rempty;
  logic              we;
  logic [RAM_AW-1:0] waddr;
  logic [RAM_AW-1:0] raddr;
  sample_t           wdata;
  sample_t           rdata;

  bank_ctrl i_ctrl (
    .iwclk       (iwclk),
    .iwreset     (iwreset),
    .wfull       (wfull),
    .wbank       (wbank),
    .wbank_busy  (wbank_busy),
    .irclk       (irclk),
    .irreset     (irreset),
    .rempty      (rempty),
    .rbank       (rbank),
    .rbank_full  (rbank_full),
    .w_any_free  (w_any_free),
    .w_all_full  (w_all_full),
    .r_any_full  (r_any_full),
    .r_all_empty (r_all_empty)
  );

  bank_ram i_ram (
    .iwclk (iwclk),
    .we    (we),
    .waddr (waddr),
    .wdata (wdata),
    .irclk (irclk),
    .raddr (raddr),
    .rdata (rdata)
  );

  // fills banks on iwclk
  bank_writer i_writer (
    .iwclk      (iwclk),
    .iwreset    (iwreset),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .in_sample  (in_sample),
    .wbank      (wbank),
    .wbank_busy (wbank_busy),
    .wfull      (wfull),
    .we         (we),
    .waddr      (waddr),
    .wdata      (wdata)
  );

  // drains banks on irclk
  bank_reader i_reader (
    .irclk      (irclk),
    .irreset    (irreset),
    .rbank      (rbank),
    .rbank_full (rbank_full),
    .rempty     (rempty),
    .raddr      (raddr),
    .rdata      (rdata),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_beat   (out_beat)
  );

endmodule

`default_nettype wire

// File: sim/frame_checker.sv
// output stream checker
`timescale 1ns/10ps
`default_nettype none

module frame_checker
  import buf_cfg_pkg::*;
  import buf_type_pkg::*;
#(
  parameter int EXP_MAX = 64
)(
  input  logic              irclk,
  input  logic              irreset,
  input  logic              out_valid,
  input  logic              out_ready,
  input  beat_t             out_beat,
  input  logic [DATA_W-1:0] exp_data [EXP_MAX],  // words in input order
  input  int                exp_count,           // whole frames only
  output int                errors,
  output int                beats                // beats transferred so far
);

  logic  stalled;     // beat was held back last cycle
  beat_t held;        // the beat that was held back
  logic  exp_last;

  // --------------------
  // sample half a cycle away from the DUT edge
  // --------------------
  always @(negedge irclk) begin
    #1;                                          // out_ready moves on this edge
    if (irreset) begin
      errors  = 0;
      beats   = 0;
      stalled = 1'b0;
      held    = '0;
    end else begin
      if (stalled) begin
        if (!out_valid) begin
          $display("out_valid dropped at %0t while a beat was stalled", $time);
          errors++;
        end else if (out_beat !== held) begin
          $display("FAILED %0t out_beat (stalled): expected %h, got %h",
                   $time, held, out_beat);
          errors++;
        end
      end
      if (out_valid && out_ready) begin
        if (beats >= exp_count) begin
          $display("extra beat %h at %0t after all %0d expected words",
                   out_beat.data, $time, exp_count);
          errors++;
        end else begin
          exp_last = (beats % BANK_WORDS) == (BANK_WORDS - 1);  // every eighth word
          if (out_beat.data !== exp_data[beats]) begin
            $display("FAILED %0t out_beat.data: expected %h, got %h",
                     $time, exp_data[beats], out_beat.data);
            errors++;
          end
          if (out_beat.last !== exp_last) begin
            $display("FAILED %0t out_beat.last: expected %b, got %b",
                     $time, exp_last, out_beat.last);
            errors++;
          end
        end
        beats++;
      end
      stalled = out_valid && !out_ready;
      held    = out_beat;
    end
  end

endmodule

`default_nettype wire

// File: sim/tb_frame_buffer.sv
// frame buffer testbench
`timescale 1ns/10ps
`default_nettype none

module tb_frame_buffer
  import buf_cfg_pkg::*;
  import buf_type_pkg::*;
();

  localparam int  N_PAT   = 43;                              // entries in the pattern file
  localparam int  N_EXP   = (N_PAT / BANK_WORDS) * BANK_WORDS; // whole frames only
  localparam int  TIMEOUT = N_PAT * 40;                      // irclk cycles
  localparam real IW_HALF = 5.5;                             // 11 ns write clock

  logic              iwclk;
  logic              iwreset;
  logic              in_valid;
  logic              in_ready;
  sample_t           in_sample;
  logic              irclk;
  logic              irreset;
  logic              out_valid;
  logic              out_ready;
  beat_t             out_beat;
  logic              w_any_free;
  logic              w_all_full;
  logic              r_any_full;
  logic              r_all_empty;

  logic [19:0]       pat [N_PAT];        // {flag nibble, data}
  logic [DATA_W-1:0] exp_words [N_PAT];
  int                chk_errors;
  int                chk_beats;
  int                tb_errors;
  int                idx;
  int                cycles = 0;
  logic              stall_random;       // 0 holds out_ready low
  logic [31:0]       rnd_state;

  frame_buffer_top i_dut (
    .iwclk       (iwclk),
    .iwreset     (iwreset),
    .in_valid    (in_valid),
    .in_ready    (in_ready),
    .in_sample   (in_sample),
    .irclk       (irclk),
    .irreset     (irreset),
    .out_valid   (out_valid),
    .out_ready   (out_ready),
    .out_beat    (out_beat),
    .w_any_free  (w_any_free),
    .w_all_full  (w_all_full),
    .r_any_full  (r_any_full),
    .r_all_empty (r_all_empty)
  );

  frame_checker #(.EXP_MAX(N_PAT)) i_chk (
    .irclk     (irclk),
    .irreset   (irreset),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_beat  (out_beat),
    .exp_data  (exp_words),
    .exp_count (N_EXP),
    .errors    (chk_errors),
    .beats     (chk_beats)
  );

  // --------------------
  // clocks and helpers
  // --------------------
  always #4 irclk = ~irclk;
  always #(IW_HALF) iwclk = ~iwclk;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic expect_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("FAILED %0t %s: expected %b, got %b", $time, name, exp, act);
      tb_errors++;
    end
  endtask

  // word moves on the posedge after a negedge that sees in_ready high
  task automatic send_word(input logic [DATA_W-1:0] word);
    @(negedge iwclk);
    in_valid       = 1'b1;
    in_sample.data = word;
    while (!in_ready) begin
      @(negedge iwclk);
    end
  endtask

  // out_ready, stalls only while a flagged word is due at the output
  always @(negedge irclk) begin
    if (stall_random) begin
      rnd_state = xorshift32(rnd_state);
      if (chk_beats < N_PAT && pat[chk_beats][19:16] != 4'h0) begin
        out_ready = (rnd_state[1:0] != 2'b00);   // ready three times in four
      end else begin
        out_ready = 1'b1;
      end
    end
  end

  // watchdog
  always @(posedge irclk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT) begin
      $display("timeout: run did not finish within %0d irclk cycles", TIMEOUT);
      $display("test failed");
      $finish;
    end
  end

  // --------------------
  // stimulus
  // --------------------
  initial begin
    irclk        = 1'b0;
    iwclk        = 1'b0;
    irreset      = 1'b1;
    iwreset      = 1'b1;
    in_valid     = 1'b0;
    in_sample    = '0;
    out_ready    = 1'b0;
    stall_random = 1'b0;
    rnd_state    = 32'h564d;
    tb_errors    = 0;
    for (int i = 0; i < N_PAT; i++) begin
      pat[i] = {4'hf, DATA_W'(i)};                // flag f marks an entry the file left out
    end
    $readmemh("sim/frame_patterns.hex", pat);
    if (pat[N_PAT-1][19:16] == 4'hf) begin
      $display("pattern file sim/frame_patterns.hex is missing or short");
      tb_errors++;
    end
    for (int i = 0; i < N_PAT; i++) begin
      exp_words[i] = pat[i][DATA_W-1:0];          // output order equals input order
    end

    fork
      begin
        repeat (5) @(negedge irclk);
        irreset = 1'b0;
      end
      begin
        repeat (5) @(negedge iwclk);
        iwreset = 1'b0;
      end
    join

    @(negedge iwclk);
    expect_bit("in_ready", 1'b1, in_ready);
    expect_bit("out_valid", 1'b0, out_valid);
    expect_bit("w_any_free", 1'b1, w_any_free);
    expect_bit("r_all_empty", 1'b1, r_all_empty);

    // fill every bank with the output stalled
    idx = 0;
    while (in_ready && idx < N_PAT) begin
      in_valid       = 1'b1;
      in_sample.data = pat[idx][DATA_W-1:0];
      @(negedge iwclk);
      idx++;
    end
    in_valid = 1'b0;
    if (idx != BNUM * BANK_WORDS) begin
      $display("FAILED %0t accepted words: expected %0d, got %0d", $time,
               BNUM * BANK_WORDS, idx);
      tb_errors++;
    end

    // all crossings settle, nothing may drain while out_ready stays low
    repeat (2 * (SYNC_LEN + 2)) @(negedge irclk);
    @(negedge iwclk);
    expect_bit("w_all_full", 1'b1, w_all_full);
    expect_bit("w_any_free", 1'b0, w_any_free);
    expect_bit("in_ready", 1'b0, in_ready);
    @(negedge irclk);
    expect_bit("r_any_full", 1'b1, r_any_full);
    expect_bit("r_all_empty", 1'b0, r_all_empty);

    // rest of the words under random stalls
    @(posedge irclk);
    stall_random = 1'b1;
    while (idx < N_PAT) begin
      send_word(pat[idx][DATA_W-1:0]);
      idx++;
    end
    @(negedge iwclk);
    in_valid = 1'b0;

    for (int n = 0; n < N_EXP * 20 && chk_beats < N_EXP; n++) begin
      @(negedge irclk);
    end
    repeat (100) @(negedge irclk);                // a partial frame would show up here
    if (chk_beats < N_EXP) begin
      $display("%0d expected words never reached the output", N_EXP - chk_beats);
      tb_errors++;
    end

    $display("errors: %0d (checker %0d, testbench %0d), beats %0d of %0d",
             chk_errors + tb_errors, chk_errors, tb_errors, chk_beats, N_EXP);
    if (chk_errors + tb_errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sim/frame_patterns.hex
// one entry per input word: flag digit, then 4 data digits
// flag 1 lets out_ready stall while that word is due at the output
// frame 0
10a00 10a11 00a22 10a33
10a44 00a55 10a66 10a77
// frame 1
11b08 11b19 11b2a 01b3b
11b4c 11b5d 01b6e 11b7f
// frame 2
02c80 12c91 12ca2 12cb3
12cc4 02cd5 12ce6 12cf7
// frame 3
13d0f 13d1e 13d2d 13d3c
03d4b 13d5a 13d69 13d78
// frame 4
14e55 04eaa 14e5a 14ea5
14e00 14eff 04e0f 14ef0
// partial frame, never leaves the buffer
15f01 15f02 15f03

// File: build.f
common/buf_cfg_pkg.sv
common/buf_type_pkg.sv
logic/pulse_sync.sv
bank/bank_ctrl.sv
bank/bank_ram.sv
logic/bank_writer.sv
logic/bank_reader.sv
logic/frame_buffer_top.sv
sim/frame_checker.sv
sim/tb_frame_buffer.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_frame_buffer
FILELIST  := build.f
OBJDIR    := obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "test passed"

clean:
	rm -rf $(OBJDIR)
